// File: hdl/perm_config.svh
`ifndef PERM_CONFIG_SVH
`define PERM_CONFIG_SVH

// buffer index width, 8192 words
`define PERM_INDEX_W 13

// one buffer RAM word
`define PERM_WORD_W 64

// shrink field, largest value in use is 3
`define PERM_SHRINK_W 2

// cycles from rd_en to rd_data valid
`define PERM_RAM_LAT 2

// return FIFO entries
// must stay above read latency plus one for full rate
`define PERM_FIFO_DEPTH 8

`endif

// File: hdl/perm_pkg.sv
`include "perm_config.svh"

package perm_pkg;

  // one buffer index
  typedef logic [`PERM_INDEX_W-1:0] index_t;

  // one RAM word
  typedef logic [`PERM_WORD_W-1:0] word_t;

  // log2 reduction of the job length
  typedef logic [`PERM_SHRINK_W-1:0] shrink_t;

  // pattern codes, each one rotates the low F index bits left by R
  // codes not listed here map to identity
  typedef enum logic [3:0] {
    PAT_ROT12_L1 = 4'd4,
    PAT_ROT12_L9 = 4'd5,
    PAT_ROT11_L8 = 4'd6,
    PAT_ROT12_L2 = 4'd10,
    PAT_ROT13_L3 = 4'd14
  } pattern_t;

  // FIFO occupancy, 0 up to full depth
  typedef logic [$clog2(`PERM_FIFO_DEPTH + 1)-1:0] level_t;

endpackage

// File: hdl/perm_stream_if.sv
`timescale 1ns/10ps

// valid/ready link with index, data word and a level back-channel
interface perm_stream_if;

  logic               valid;
  logic               ready;
  perm_pkg::index_t   index;
  perm_pkg::word_t    word;
  // occupancy seen by the source, only meaningful on the return link
  perm_pkg::level_t   level;

  modport src (
    output valid, index, word,
    input  ready, level
  );

  modport dst (
    input  valid, index, word,
    output ready, level
  );

  // observation only
  modport mon (
    input valid, ready, index, word, level
  );

endinterface

// File: hdl/perm_addr_gen.sv
`timescale 1ns/10ps

`include "perm_config.svh"

module perm_addr_gen (
  input  logic                clk,
  input  logic                rstn,
  input  logic                start,
  input  perm_pkg::pattern_t  pattern,
  input  perm_pkg::shrink_t   shrink,
  output logic                rd_en,
  output perm_pkg::index_t    rd_addr,
  input  perm_pkg::word_t     rd_data,
  output logic                active,
  perm_stream_if.src          ret
);

  localparam int LAT = `PERM_RAM_LAT;
  localparam int INF_W = $clog2(LAT + 2);
  localparam perm_pkg::index_t ALL_ONES = '1;

  perm_pkg::pattern_t  pattern_q;
  perm_pkg::shrink_t   shrink_q;
  perm_pkg::index_t    rd_cnt;
  perm_pkg::index_t    last_idx;
  perm_pkg::index_t    rot_idx;
  logic [INF_W-1:0]    inflight;
  logic                credit_ok;
  logic [LAT-1:0]      vpipe;
  perm_pkg::index_t    ipipe [LAT];

  // rotate low f bits left by r, upper bits pass
  function automatic perm_pkg::index_t rotl(perm_pkg::index_t idx, int f, int r);
    perm_pkg::index_t res;
    int src;
    res = idx;
    for (int i = 0; i < `PERM_INDEX_W; i++) begin
      if (i < f) begin
        src = i - r;
        if (src < 0) begin
          src = src + f;
        end
        res[i] = idx[src];
      end
    end
    return res;
  endfunction

  // N-1 for the latched job
  assign last_idx = ALL_ONES >> shrink_q;

  // reads in flight plus stored entries must fit the FIFO
  assign credit_ok = (int'(inflight) + int'(ret.level)) < `PERM_FIFO_DEPTH;
  assign rd_en     = active && credit_ok;
  assign rd_addr   = rd_cnt;

  always_comb begin
    case (pattern_q)
      perm_pkg::PAT_ROT12_L1: rot_idx = rotl(rd_cnt, 12, 1);
      perm_pkg::PAT_ROT12_L9: rot_idx = rotl(rd_cnt, 12, 9);
      perm_pkg::PAT_ROT11_L8: rot_idx = rotl(rd_cnt, 11, 8);
      perm_pkg::PAT_ROT12_L2: rot_idx = rotl(rd_cnt, 12, 2);
      perm_pkg::PAT_ROT13_L3: rot_idx = rotl(rd_cnt, 13, 3);
      // everything else keeps the index
      default:                rot_idx = rd_cnt;
    endcase
  end

  // job state and read counter
  always_ff @(posedge clk) begin
    if (!rstn) begin
      active    <= 1'b0;
      rd_cnt    <= '0;
      pattern_q <= perm_pkg::pattern_t'(4'd0);
      shrink_q  <= '0;
    end else if (start) begin
      active    <= 1'b1;
      rd_cnt    <= '0;
      pattern_q <= pattern;
      shrink_q  <= shrink;
    end else if (rd_en) begin
      rd_cnt <= rd_cnt + 1'b1;
      // last read issued
      if (rd_cnt == last_idx) begin
        active <= 1'b0;
      end
    end
  end

  // reads issued whose data has not reached the FIFO
  always_ff @(posedge clk) begin
    if (!rstn) begin
      inflight <= '0;
    end else begin
      case ({rd_en, ret.valid})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase
    end
  end

  // valid bits, cleared on reset
  always_ff @(posedge clk) begin
    if (!rstn) begin
      vpipe <= '0;
    end else begin
      vpipe[0] <= rd_en;
      for (int i = 1; i < LAT; i++) begin
        vpipe[i] <= vpipe[i-1];
      end
    end
  end

  // target index rides along so it meets rd_data
  always_ff @(posedge clk) begin
    ipipe[0] <= rot_idx;
    for (int i = 1; i < LAT; i++) begin
      ipipe[i] <= ipipe[i-1];
    end
  end

  assign ret.valid = vpipe[LAT-1];
  assign ret.index = ipipe[LAT-1];
  assign ret.word  = rd_data;

  // counter and pipe must agree, at most LAT reads outstanding
  a_inflight_max: assert property (@(posedge clk) disable iff (!rstn)
    int'(inflight) <= LAT)
    else $error("read in-flight count above RAM latency");

  // top only forwards start while idle
  a_start_idle: assert property (@(posedge clk) disable iff (!rstn)
    start |-> !active)
    else $error("start accepted during active job");

endmodule

// File: hdl/perm_ret_fifo.sv
`timescale 1ns/10ps

`include "perm_config.svh"

module perm_ret_fifo #(
  parameter int DEPTH = `PERM_FIFO_DEPTH
) (
  input  logic        clk,
  input  logic        rstn,
  perm_stream_if.dst  in,
  perm_stream_if.src  out
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // payload storage
  perm_pkg::index_t   mem_idx  [DEPTH];
  perm_pkg::word_t    mem_word [DEPTH];

  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  perm_pkg::level_t   count;
  logic               push;
  logic               pop;

  assign in.ready  = (int'(count) != DEPTH);
  assign in.level  = count;
  assign out.valid = (count != '0);
  assign out.index = mem_idx[rd_ptr];
  assign out.word  = mem_word[rd_ptr];

  assign push = in.valid && in.ready;
  assign pop  = out.valid && out.ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem_idx[wr_ptr]  <= in.index;
      mem_word[wr_ptr] <= in.word;
    end
  end

  // pointers wrap at DEPTH-1 so any depth works
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // read credit in the generator keeps data from arriving while full
  a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
    in.valid |-> in.ready)
    else $error("return data arrived while FIFO full");

  // occupancy must agree with the pointer distance
  a_count_ptr: assert property (@(posedge clk) disable iff (!rstn)
    (int'(count) % DEPTH) == ((int'(wr_ptr) - int'(rd_ptr) + DEPTH) % DEPTH))
    else $error("FIFO occupancy does not match pointers");

endmodule

// File: hdl/perm_writeback.sv
`timescale 1ns/10ps

module perm_writeback (
  input  logic               clk,
  input  logic               rstn,
  input  logic               start,
  input  perm_pkg::shrink_t  shrink,
  perm_stream_if.dst         wb,
  output logic               wr_valid,
  output perm_pkg::index_t   wr_addr,
  output perm_pkg::word_t    wr_data,
  input  logic               wr_ready,
  output logic               pending
);

  localparam perm_pkg::index_t ALL_ONES = '1;

  perm_pkg::shrink_t  shrink_q;
  perm_pkg::index_t   wr_cnt;
  perm_pkg::index_t   last_idx;
  logic               wr_fire;

  // write port straight from the FIFO head
  assign wr_valid = wb.valid;
  assign wr_addr  = wb.index;
  assign wr_data  = wb.word;
  // RAM back-pressure goes back to the FIFO
  assign wb.ready = wr_ready;
  // level only matters on the return link
  assign wb.level = '0;

  assign wr_fire  = wr_valid && wr_ready;
  assign last_idx = ALL_ONES >> shrink_q;

  // completed writes, counted from zero
  always_ff @(posedge clk) begin
    if (!rstn) begin
      pending  <= 1'b0;
      wr_cnt   <= '0;
      shrink_q <= '0;
    end else if (start) begin
      pending  <= 1'b1;
      wr_cnt   <= '0;
      shrink_q <= shrink;
    end else if (wr_fire) begin
      wr_cnt <= wr_cnt + 1'b1;
      // write N-1 done, job ends
      if (wr_cnt == last_idx) begin
        pending <= 1'b0;
      end
    end
  end

  // FIFO head must hold while the RAM stalls
  a_wr_stable: assert property (@(posedge clk) disable iff (!rstn)
    wr_valid && !wr_ready |=> wr_valid && $stable(wr_addr) && $stable(wr_data))
    else $error("write port changed while stalled");

endmodule

// File: hdl/perm_top.sv
`timescale 1ns/10ps

module perm_top (
  input  logic                clk,
  input  logic                rstn,
  input  logic                start,
  input  perm_pkg::pattern_t  pattern,
  input  perm_pkg::shrink_t   shrink,
  output logic                busy,
  output logic                rd_en,
  output perm_pkg::index_t    rd_addr,
  input  perm_pkg::word_t     rd_data,
  output logic                wr_valid,
  output perm_pkg::index_t    wr_addr,
  output perm_pkg::word_t     wr_data,
  input  logic                wr_ready
);

  logic  active;
  logic  pending;
  logic  start_ok;

  // start only counts while idle
  assign start_ok = start && !busy;
  assign busy     = active || pending;

  // generator to FIFO
  perm_stream_if ret_link ();
  // FIFO to write-back
  perm_stream_if wb_link ();

  perm_addr_gen i_addr_gen (
    .clk     (clk),
    .rstn    (rstn),
    .start   (start_ok),
    .pattern (pattern),
    .shrink  (shrink),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .active  (active),
    .ret     (ret_link.src)
  );

  perm_ret_fifo i_ret_fifo (
    .clk  (clk),
    .rstn (rstn),
    .in   (ret_link.dst),
    .out  (wb_link.src)
  );

  perm_writeback i_writeback (
    .clk      (clk),
    .rstn     (rstn),
    .start    (start_ok),
    .shrink   (shrink),
    .wb       (wb_link.dst),
    .wr_valid (wr_valid),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_ready (wr_ready),
    .pending  (pending)
  );

endmodule

// File: sim/perm_tb_checks.svh
`ifndef PERM_TB_CHECKS_SVH
`define PERM_TB_CHECKS_SVH

// buffer index compare
task automatic check_index(string name, perm_pkg::index_t got, perm_pkg::index_t exp);
  if (got !== exp) begin
    $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    stop_with_failure();
  end
endtask

// RAM word compare
task automatic check_word(string name, perm_pkg::word_t got, perm_pkg::word_t exp);
  if (got !== exp) begin
    $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    stop_with_failure();
  end
endtask

// single bit compare, busy and other flags
task automatic check_flag(string name, logic got, logic exp);
  if (got !== exp) begin
    $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    stop_with_failure();
  end
endtask

// target address of index idx under a pattern code
// low f bits rotated left by r, upper bits kept
function automatic perm_pkg::index_t expected_addr(logic [3:0] code, perm_pkg::index_t idx);
  int f;
  int r;
  int mask;
  int low;
  int rot;
  f = 0;
  r = 0;
  case (code)
    4'd4:    begin f = 12; r = 1; end
    4'd5:    begin f = 12; r = 9; end
    4'd6:    begin f = 11; r = 8; end
    4'd10:   begin f = 12; r = 2; end
    4'd14:   begin f = 13; r = 3; end
    default: f = 0;
  endcase
  // identity for every other code
  if (f == 0) begin
    return idx;
  end
  mask = (1 << f) - 1;
  low  = int'(idx) & mask;
  rot  = ((low << r) | (low >> (f - r))) & mask;
  return perm_pkg::index_t'((int'(idx) & ~mask) | rot);
endfunction

`endif

// File: sim/perm_tb.sv
`timescale 1ns/10ps

`include "perm_config.svh"

module perm_tb;

  localparam int LAT   = `PERM_RAM_LAT;
  localparam int DEPTH = `PERM_FIFO_DEPTH;
  localparam int SIZE  = 1 << `PERM_INDEX_W;
  localparam int ROWS  = 9;
  // odd multiplier for the RAM contents
  localparam perm_pkg::word_t MULT = 64'h9e37_79b9_7f4a_7c15;

  logic                clk = 1'b0;
  logic                rstn;
  logic                start;
  perm_pkg::pattern_t  pattern;
  perm_pkg::shrink_t   shrink;
  logic                busy;
  logic                rd_en;
  perm_pkg::index_t    rd_addr;
  perm_pkg::word_t     rd_data;
  logic                wr_valid;
  perm_pkg::index_t    wr_addr;
  perm_pkg::word_t     wr_data;
  logic                wr_ready = 1'b1;

  // job table with pattern code, shrink, wr_ready duty in percent and a second start
  logic [3:0] tab_code   [ROWS] = '{4'd0, 4'd4, 4'd5, 4'd6, 4'd10, 4'd14, 4'd5, 4'd10, 4'd14};
  int         tab_shrink [ROWS] = '{3, 2, 2, 2, 2, 2, 1, 2, 0};
  int         tab_duty   [ROWS] = '{100, 100, 100, 100, 100, 100, 50, 50, 70};
  bit         tab_late   [ROWS] = '{0, 0, 0, 0, 0, 0, 0, 1, 0};

  // RAM read pipe and write shadow
  perm_pkg::index_t  ram_pipe [LAT] = '{default: '0};
  perm_pkg::word_t   shadow [SIZE];
  int                wr_job [SIZE];

  int          total_reads  = 0;
  int          total_writes = 0;
  int          base_reads   = 0;
  int          base_writes  = 0;
  int          job_no       = 0;
  int          duty         = 100;
  logic [3:0]  cur_code     = 4'd0;
  int          cycles       = 0;
  int          cycle_limit  = 2000;

  task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1, "run stopped at the first error");
  endtask

  `include "perm_tb_checks.svh"

  // contents of the buffer RAM at idx
  function automatic perm_pkg::word_t known_word(perm_pkg::index_t idx);
    return perm_pkg::word_t'(idx) * MULT + 64'd1;
  endfunction

  perm_top i_dut (
    .clk      (clk),
    .rstn     (rstn),
    .start    (start),
    .pattern  (pattern),
    .shrink   (shrink),
    .busy     (busy),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .wr_valid (wr_valid),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_ready (wr_ready)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  // fixed latency read with the address shifting along the data slots
  always @(posedge clk) begin
    ram_pipe[0] <= rd_addr;
    for (int i = 1; i < LAT; i++) begin
      ram_pipe[i] <= ram_pipe[i-1];
    end
  end

  assign rd_data = known_word(ram_pipe[LAT-1]);

  // write port back-pressure
  always @(negedge clk) begin
    if (duty >= 100) begin
      wr_ready <= 1'b1;
    end else begin
      wr_ready <= (($urandom % 100) < duty);
    end
  end

  // reads leave in index order
  // writes follow in read order and land in the shadow
  always @(posedge clk) begin
    if (rstn) begin
      if (total_reads - total_writes > DEPTH + LAT) begin
        $display("reads ran more than FIFO depth plus latency ahead of the writes");
        stop_with_failure();
      end
      if (rd_en) begin
        check_index("rd_addr", rd_addr, perm_pkg::index_t'(total_reads - base_reads));
        total_reads <= total_reads + 1;
      end
      if (wr_valid && wr_ready) begin
        check_index("wr_addr", wr_addr,
          expected_addr(cur_code, perm_pkg::index_t'(total_writes - base_writes)));
        check_word("wr_data", wr_data,
          known_word(perm_pkg::index_t'(total_writes - base_writes)));
        shadow[wr_addr] <= wr_data;
        wr_job[wr_addr] <= job_no;
        total_writes    <= total_writes + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      stop_with_failure();
    end
  end

  initial begin
    int n;
    perm_pkg::index_t addr;
    void'($urandom(20));
    rstn    = 1'b0;
    start   = 1'b0;
    pattern = perm_pkg::pattern_t'(4'd0);
    shrink  = '0;
    // budget of 4 cycles per word
    for (int r = 0; r < ROWS; r++) begin
      cycle_limit += 4 * (SIZE >> tab_shrink[r]);
    end
    repeat (16) @(negedge clk);
    rstn = 1'b1;
    // quiet outputs until the first start
    repeat (4) begin
      @(negedge clk);
      check_flag("busy", busy, 1'b0);
      check_flag("rd_en", rd_en, 1'b0);
      check_flag("wr_valid", wr_valid, 1'b0);
    end
    for (int r = 0; r < ROWS; r++) begin
      n           = SIZE >> tab_shrink[r];
      duty        = tab_duty[r];
      cur_code    = tab_code[r];
      job_no      = r + 1;
      base_reads  = total_reads;
      base_writes = total_writes;
      start       = 1'b1;
      pattern     = perm_pkg::pattern_t'(tab_code[r]);
      shrink      = perm_pkg::shrink_t'(tab_shrink[r]);
      @(negedge clk);
      start = 1'b0;
      check_flag("busy", busy, 1'b1);
      if (tab_late[r]) begin
        repeat (20) @(negedge clk);
        check_flag("busy", busy, 1'b1);
        // other pattern and length that must be dropped
        start   = 1'b1;
        pattern = perm_pkg::PAT_ROT11_L8;
        shrink  = perm_pkg::shrink_t'(3);
        @(negedge clk);
        start = 1'b0;
      end
      while (busy) begin
        @(negedge clk);
      end
      if (total_reads - base_reads != n) begin
        $display("job %0d issued %0d reads instead of %0d", job_no,
          total_reads - base_reads, n);
        stop_with_failure();
      end
      if (total_writes - base_writes != n) begin
        $display("job %0d made %0d writes instead of %0d", job_no,
          total_writes - base_writes, n);
        stop_with_failure();
      end
      // every word of this job at its permuted address
      for (int i = 0; i < n; i++) begin
        addr = expected_addr(tab_code[r], perm_pkg::index_t'(i));
        if (wr_job[addr] != job_no) begin
          $display("address 0x%0h was not written by job %0d", addr, job_no);
          stop_with_failure();
        end
        check_word("shadow", shadow[addr], known_word(perm_pkg::index_t'(i)));
      end
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: sources.f
+incdir+hdl
+incdir+sim
hdl/perm_pkg.sv
hdl/perm_stream_if.sv
hdl/perm_addr_gen.sv
hdl/perm_ret_fifo.sv
hdl/perm_writeback.sv
hdl/perm_top.sv
sim/perm_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module perm_tb -f sources.f -o perm_sim \
  && ./obj_dir/perm_sim > sim.log 2>&1 \
  || echo "build or simulation returned an error status"
touch sim.log
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "FAIL: simulation did not complete"; exit 1; }
echo "PASS"
